/* logic/lanzones_cfg.svh */
`ifndef LANZONES_CFG_SVH
`define LANZONES_CFG_SVH

// data and address width
`define LZ_XLEN 32

// register file geometry, x0 included
`define LZ_REGS   32
`define LZ_REG_AW 5

// word addressed, one instruction per word
`define LZ_PC_STEP 1

// bits 6..0 all set halt the core
`define LZ_STOP_OPC 7'b1111111

`endif

/* logic/lanzonesPkg.sv */
`include "lanzones_cfg.svh"

package lanzonesPkg;

   typedef logic [`LZ_XLEN-1:0]   word_t;
   typedef logic [`LZ_REG_AW-1:0] regIdx_t;
   typedef logic [11:0]           imm12_t;   // raw I/S immediate field

   // values match bits 6..0 of the instruction
   typedef enum logic [6:0] {
      OP_NOP   = 7'b0000000,   // anything not listed below
      OP_LOAD  = 7'b0000011,
      OP_STORE = 7'b0100011,
      OP_ADD   = 7'b0110011,
      OP_LUI   = 7'b0110111,
      OP_STOP  = `LZ_STOP_OPC
   } opcode_e;

   typedef enum logic [1:0] {
      ST_HALTED = 2'd0,
      ST_FETCH  = 2'd1,   // request out, or about to go out
      ST_EXEC   = 2'd2,
      ST_MEM    = 2'd3    // data access in flight
   } seqState_e;

endpackage

/* logic/instrDecoder.sv */
module instrDecoder (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 loadInstr,
   input  lanzonesPkg::word_t   RData,
   output lanzonesPkg::opcode_e opcode,
   output lanzonesPkg::regIdx_t rd,
   output lanzonesPkg::regIdx_t rs1,
   output lanzonesPkg::regIdx_t rs2,
   output lanzonesPkg::word_t   imm
);

   import lanzonesPkg::*;

   word_t  instr;
   imm12_t immI;
   imm12_t immS;

   // zero decodes as a no-op
   always_ff @(posedge clk) begin
      if (!rstn) begin
         instr <= '0;
      end
      else if (loadInstr) begin
         instr <= RData;
      end
   end

   always_comb begin
      case (instr[6:0])
         OP_LUI: begin
            opcode = OP_LUI;
         end
         OP_ADD: begin
            opcode = OP_ADD;
         end
         OP_LOAD: begin
            opcode = OP_LOAD;
         end
         OP_STORE: begin
            opcode = OP_STORE;
         end
         OP_STOP: begin
            opcode = OP_STOP;
         end
         default: begin
            opcode = OP_NOP;   // unknown opcodes skipped
         end
      endcase
   end

   assign rd  = instr[11:7];
   assign rs1 = instr[19:15];
   assign rs2 = instr[24:20];

   assign immI = instr[31:20];
   assign immS = {instr[31:25], instr[11:7]};   // S-type split field

   always_comb begin
      case (opcode)
         OP_LUI: begin
            imm = {instr[31:12], 12'b0};
         end
         OP_LOAD: begin
            imm = {{20{immI[11]}}, immI};
         end
         OP_STORE: begin
            imm = {{20{immS[11]}}, immS};
         end
         default: begin
            imm = '0;
         end
      endcase
   end

   // decoded opcode is always a known class
   assert property (@(posedge clk) disable iff (!rstn)
      opcode inside {OP_NOP, OP_LUI, OP_ADD, OP_LOAD, OP_STORE, OP_STOP});

endmodule

/* logic/registerFile.sv */
`include "lanzones_cfg.svh"

module registerFile (
   input  logic                 clk,
   input  logic                 rstn,
   input  lanzonesPkg::regIdx_t rs1,
   input  lanzonesPkg::regIdx_t rs2,
   output lanzonesPkg::word_t   rs1Data,
   output lanzonesPkg::word_t   rs2Data,
   input  logic                 wrEn,
   input  lanzonesPkg::regIdx_t wrIdx,
   input  lanzonesPkg::word_t   wrData
);

   import lanzonesPkg::*;

   // x0 has no storage
   word_t regs [1:`LZ_REGS-1];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 1; i < `LZ_REGS; i++) begin
            regs[i] <= '0;
         end
      end
      else if (wrEn && (wrIdx != '0)) begin   // writes to x0 dropped
         regs[wrIdx] <= wrData;
      end
   end

   always_comb begin
      if (rs1 == '0) begin
         rs1Data = '0;
      end
      else begin
         rs1Data = regs[rs1];
      end
   end

   always_comb begin
      if (rs2 == '0) begin
         rs2Data = '0;
      end
      else begin
         rs2Data = regs[rs2];
      end
   end

   // x0 reads as zero on both ports, whatever was written before
   assert property (@(posedge clk) disable iff (!rstn)
      ((rs1 == '0) |-> (rs1Data == '0)) and ((rs2 == '0) |-> (rs2Data == '0)));

endmodule

/* logic/busSequencer.sv */
`include "lanzones_cfg.svh"

module busSequencer (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 RVld,
   input  logic                 LEn,
   input  lanzonesPkg::word_t   RData,
   output logic                 RRdy,
   output logic                 RWEn,
   output logic                 Halt,
   output lanzonesPkg::word_t   RAddr,
   output lanzonesPkg::word_t   RWData,
   output logic                 loadInstr,
   input  lanzonesPkg::opcode_e opcode,
   input  lanzonesPkg::regIdx_t rd,
   input  lanzonesPkg::word_t   imm,
   input  lanzonesPkg::word_t   rs1Data,
   input  lanzonesPkg::word_t   rs2Data,
   output logic                 wrEn,
   output lanzonesPkg::regIdx_t wrIdx,
   output lanzonesPkg::word_t   wrData
);

   import lanzonesPkg::*;

   seqState_e state;
   word_t     pc;
   word_t     sum;
   word_t     memAddr;
   logic      issueFetch;   // raise RRdy toward pc on this edge
   logic      issueMem;     // raise RRdy toward memAddr on this edge

   assign sum     = rs1Data + rs2Data;
   assign memAddr = rs1Data + imm;

   assign loadInstr = (state == ST_FETCH) && RVld;

   always_comb begin
      issueFetch = 1'b0;
      issueMem   = 1'b0;
      case (state)
         ST_HALTED: begin
            issueFetch = LEn;
         end
         ST_FETCH: begin
            issueFetch = !RRdy;   // one idle cycle after a data access
         end
         ST_EXEC: begin
            issueFetch = (opcode == OP_LUI) || (opcode == OP_ADD) || (opcode == OP_NOP);
            issueMem   = (opcode == OP_LOAD) || (opcode == OP_STORE);
         end
         default: begin
            issueFetch = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= ST_HALTED;
         pc    <= '0;
         RRdy  <= 1'b0;
         RWEn  <= 1'b0;
         Halt  <= 1'b1;
      end
      else begin
         if (issueFetch || issueMem) begin
            RRdy <= 1'b1;
            RWEn <= issueMem && (opcode == OP_STORE);
         end
         else if (RVld) begin
            RRdy <= 1'b0;
            RWEn <= 1'b0;
         end

         case (state)
            ST_HALTED: begin
               if (LEn) begin
                  Halt  <= 1'b0;
                  state <= ST_FETCH;
               end
            end
            ST_FETCH: begin
               if (RVld) begin
                  pc    <= pc + word_t'(`LZ_PC_STEP);
                  state <= ST_EXEC;
               end
            end
            ST_EXEC: begin
               if (opcode == OP_STOP) begin
                  Halt  <= 1'b1;   // RRdy stays low
                  state <= ST_HALTED;
               end
               else if (issueMem) begin
                  state <= ST_MEM;
               end
               else begin
                  state <= ST_FETCH;
               end
            end
            ST_MEM: begin
               if (RVld) begin
                  state <= ST_FETCH;
               end
            end
            default: begin
               state <= ST_HALTED;
            end
         endcase
      end
   end

   // request payload, only looked at while RRdy is high
   always_ff @(posedge clk) begin
      if (issueFetch) begin
         RAddr <= pc;
      end
      else if (issueMem) begin
         RAddr  <= memAddr;
         RWData <= rs2Data;
      end
   end

   // LUI/ADD write at the end of EXEC, LW on its data response
   assign wrEn = ((state == ST_EXEC) && ((opcode == OP_LUI) || (opcode == OP_ADD)))
              || ((state == ST_MEM) && RVld && (opcode == OP_LOAD));
   assign wrIdx = rd;

   always_comb begin
      case (opcode)
         OP_LUI: begin
            wrData = imm;
         end
         OP_ADD: begin
            wrData = sum;
         end
         default: begin
            wrData = RData;   // load data
         end
      endcase
   end

   assert property (@(posedge clk) disable iff (!rstn) !(RRdy && Halt));
   assert property (@(posedge clk) disable iff (!rstn) RWEn |-> RRdy);

   // an open request holds its fields until the response
   assert property (@(posedge clk) disable iff (!rstn)
      RRdy && !RVld |=> RRdy && $stable(RAddr) && $stable(RWEn));

endmodule

/* logic/lanzonesCore.sv */
module lanzonesCore (
   input  logic               clk,
   input  logic               rstn,
   input  logic               RVld,
   input  logic               LEn,
   input  lanzonesPkg::word_t RData,
   output logic               RRdy,
   output logic               RWEn,
   output logic               Halt,
   output lanzonesPkg::word_t RAddr,
   output lanzonesPkg::word_t RWData
);

   import lanzonesPkg::*;

   logic     loadInstr;
   opcode_e  opcode;
   regIdx_t  rd;
   regIdx_t  rs1;
   regIdx_t  rs2;
   word_t    imm;
   word_t    rs1Data;
   word_t    rs2Data;
   logic     wrEn;
   regIdx_t  wrIdx;
   word_t    wrData;

   instrDecoder uDec (
      .clk       (clk),
      .rstn      (rstn),
      .loadInstr (loadInstr),
      .RData     (RData),
      .opcode    (opcode),
      .rd        (rd),
      .rs1       (rs1),
      .rs2       (rs2),
      .imm       (imm)
   );

   registerFile uRegs (
      .clk     (clk),
      .rstn    (rstn),
      .rs1     (rs1),
      .rs2     (rs2),
      .rs1Data (rs1Data),
      .rs2Data (rs2Data),
      .wrEn    (wrEn),
      .wrIdx   (wrIdx),
      .wrData  (wrData)
   );

   busSequencer uSeq (
      .clk       (clk),
      .rstn      (rstn),
      .RVld      (RVld),
      .LEn       (LEn),
      .RData     (RData),
      .RRdy      (RRdy),
      .RWEn      (RWEn),
      .Halt      (Halt),
      .RAddr     (RAddr),
      .RWData    (RWData),
      .loadInstr (loadInstr),
      .opcode    (opcode),
      .rd        (rd),
      .imm       (imm),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data),
      .wrEn      (wrEn),
      .wrIdx     (wrIdx),
      .wrData    (wrData)
   );

endmodule

/* sim/lanzonesTb.sv */
`include "lanzones_cfg.svh"

module lanzonesTb;

   import lanzonesPkg::*;

   localparam int PERIOD           = 20;
   localparam int RESET_CYCLES     = 10;
   localparam int IDLE_CYCLES      = 5;
   localparam int PROG_LEN         = 100;
   localparam int MID_STOP         = 49;   // first halt that a second LEn resumes
   localparam int CYCLES_PER_INSTR = 12;
   localparam int WATCHDOG_TIME    =
      (PROG_LEN * CYCLES_PER_INSTR + RESET_CYCLES + 3 * IDLE_CYCLES) * PERIOD;

   // RV32 major opcodes
   localparam logic [6:0] LUI_OPC   = 7'b0110111;
   localparam logic [6:0] ADD_OPC   = 7'b0110011;
   localparam logic [6:0] LOAD_OPC  = 7'b0000011;
   localparam logic [6:0] STORE_OPC = 7'b0100011;
   localparam logic [6:0] STOP_OPC  = 7'b1111111;

   logic  clk = 1'b0;
   logic  rstn;
   logic  RVld;
   logic  LEn;
   word_t RData;
   logic  RRdy;
   logic  RWEn;
   logic  Halt;
   word_t RAddr;
   word_t RWData;

   word_t rngState = 32'd49;
   int    errCount = 0;
   int    checkCount = 0;
   int    reqCount = 0;

   word_t busMem [word_t];     // responder side
   word_t modelMem [word_t];
   word_t modelRegs [0:`LZ_REGS-1];
   word_t modelPc = '0;

   // predicted bus requests in issue order
   word_t expAddr [$];
   logic  expWen [$];
   word_t expData [$];

   logic  pending = 1'b0;
   int    delay = 0;
   word_t heldAddr;
   logic  heldWen;

   lanzonesCore UUT (
      .clk    (clk),
      .rstn   (rstn),
      .RVld   (RVld),
      .LEn    (LEn),
      .RData  (RData),
      .RRdy   (RRdy),
      .RWEn   (RWEn),
      .Halt   (Halt),
      .RAddr  (RAddr),
      .RWData (RWData)
   );

   always #(PERIOD / 2) clk = ~clk;

   function automatic word_t xorshift32(input word_t x);
      word_t s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic word_t nextRand();
      rngState = xorshift32(rngState);
      return rngState;
   endfunction

   // contents of data words never written
   function automatic word_t fillWord(input word_t addr);
      return (addr * 32'h9E3779B1) ^ 32'hC3A50F1E;
   endfunction

   function automatic word_t busRead(input word_t addr);
      if (busMem.exists(addr)) begin
         return busMem[addr];
      end
      return fillWord(addr);
   endfunction

   function automatic word_t modelRead(input word_t addr);
      if (modelMem.exists(addr)) begin
         return modelMem[addr];
      end
      return fillWord(addr);
   endfunction

   task automatic checkWord(input string name, input word_t exp, input word_t act);
      checkCount++;
      if (act !== exp) begin
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
         errCount++;
      end
   endtask

   task automatic checkBit(input string name, input logic exp, input logic act);
      checkCount++;
      if (act !== exp) begin
         $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
         errCount++;
      end
   endtask

   task automatic waitCycle();
      @(posedge clk);
      #2;
   endtask

   task automatic buildProgram();
      word_t       r;
      word_t       r2;
      word_t       pick;
      word_t       instr;
      regIdx_t     rd;
      regIdx_t     rs1;
      regIdx_t     rs2;
      logic [11:0] memOff;
      logic [6:0]  badOpc;
      for (int i = 0; i < PROG_LEN; i++) begin
         r = nextRand();
         r2 = nextRand();
         pick = nextRand() % 20;
         rd = {1'b0, r[3:0]};   // x0..x15 so results get reused
         rs1 = {1'b0, r[7:4]};
         rs2 = {1'b0, r[11:8]};
         memOff = 12'd256 + {2'b00, r[19:16], 1'b0, r[20:16]};   // 32 slots in 256..1247
         case (r2[1:0])
            2'd0: badOpc = 7'b0010011;
            2'd1: badOpc = 7'b1100011;
            default: badOpc = 7'b1101111;
         endcase
         if (i == MID_STOP || i == PROG_LEN - 1) begin
            instr = {r2[31:7], STOP_OPC};
         end
         else if (pick < 5) begin
            instr = {r2[31:12], rd, LUI_OPC};
         end
         else if (pick < 11) begin
            instr = {7'b0000000, rs2, rs1, 3'b000, rd, ADD_OPC};
         end
         else if (pick < 15) begin
            instr = {memOff, 5'd0, 3'b010, rd, LOAD_OPC};
         end
         else if (pick < 19) begin
            instr = {memOff[11:5], rs2, 5'd0, 3'b010, memOff[4:0], STORE_OPC};
         end
         else begin
            instr = {r2[31:7], badOpc};
         end
         busMem[i] = instr;
         modelMem[i] = instr;
      end
   endtask

   task automatic pushRequest(input word_t addr, input logic wen, input word_t data);
      expAddr.push_back(addr);
      expWen.push_back(wen);
      expData.push_back(data);
   endtask

   task automatic writeReg(input regIdx_t idx, input word_t val);
      if (idx != 0) begin
         modelRegs[idx] = val;
      end
   endtask

   // runs the ISA model up to the next stop word
   task automatic predictSegment();
      word_t   instr;
      word_t   addr;
      word_t   val;
      regIdx_t rd;
      regIdx_t rs1;
      regIdx_t rs2;
      logic    done;
      int      steps;
      done = 1'b0;
      steps = 0;
      while (!done && steps < PROG_LEN) begin
         pushRequest(modelPc, 1'b0, '0);
         instr = modelRead(modelPc);
         modelPc = modelPc + `LZ_PC_STEP;
         steps++;
         rd = instr[11:7];
         rs1 = instr[19:15];
         rs2 = instr[24:20];
         case (instr[6:0])
            LUI_OPC: writeReg(rd, {instr[31:12], 12'h000});
            ADD_OPC: writeReg(rd, modelRegs[rs1] + modelRegs[rs2]);
            LOAD_OPC: begin
               addr = modelRegs[rs1] + {{20{instr[31]}}, instr[31:20]};
               pushRequest(addr, 1'b0, '0);
               writeReg(rd, modelRead(addr));
            end
            STORE_OPC: begin
               addr = modelRegs[rs1] + {{20{instr[31]}}, instr[31:25], instr[11:7]};
               val = modelRegs[rs2];
               pushRequest(addr, 1'b1, val);
               modelMem[addr] = val;
            end
            STOP_OPC: done = 1'b1;
            default: ;   // unknown opcode has no effect
         endcase
      end
   endtask

   task automatic takeRequest();
      word_t addr;
      logic  wen;
      word_t data;
      reqCount++;
      if (expAddr.size() == 0) begin
         $display("unexpected bus request to %h at %0t", RAddr, $time);
         errCount++;
      end
      else begin
         addr = expAddr.pop_front();
         wen = expWen.pop_front();
         data = expData.pop_front();
         checkWord("RAddr", addr, RAddr);
         checkBit("RWEn", wen, RWEn);
         if (wen) begin
            checkWord("RWData", data, RWData);
         end
      end
      heldAddr = RAddr;
      heldWen = RWEn;
      pending = 1'b1;
      delay = int'(nextRand() % 4);   // RVld 1..4 cycles after RRdy
   endtask

   // memory responder
   always begin
      @(posedge clk);
      #2;
      if (RVld) begin
         RVld = 1'b0;
         checkBit("RRdy", 1'b0, RRdy);   // drops on the response edge
      end
      else if (RRdy) begin
         if (!pending) begin
            takeRequest();
         end
         else begin
            checkWord("RAddr", heldAddr, RAddr);
            checkBit("RWEn", heldWen, RWEn);
         end
         if (delay == 0) begin
            if (RWEn) begin
               busMem[RAddr] = RWData;
               RData = nextRand();   // ignored on writes
            end
            else begin
               RData = busRead(RAddr);
            end
            RVld = 1'b1;
            pending = 1'b0;
         end
         else begin
            delay--;
         end
      end
   end

   // one LEn pulse and run until the core halts again
   task automatic runSegment();
      word_t startPc;
      startPc = modelPc;
      predictSegment();
      LEn = 1'b1;
      waitCycle();
      LEn = 1'b0;
      checkBit("Halt", 1'b0, Halt);
      checkBit("RRdy", 1'b1, RRdy);
      checkWord("RAddr", startPc, RAddr);
      checkBit("RWEn", 1'b0, RWEn);
      while (!Halt) begin
         waitCycle();
      end
      if (expAddr.size() != 0) begin
         $display("core halted at %0t with %0d predicted requests not issued",
                  $time, expAddr.size());
         errCount++;
      end
      repeat (IDLE_CYCLES) begin
         waitCycle();
         checkBit("RRdy", 1'b0, RRdy);
         checkBit("Halt", 1'b1, Halt);
      end
   endtask

   initial begin
      rstn = 1'b0;
      LEn = 1'b0;
      RVld = 1'b0;
      RData = '0;
      for (int i = 0; i < `LZ_REGS; i++) begin
         modelRegs[i] = '0;
      end
      buildProgram();
      repeat (RESET_CYCLES) begin
         waitCycle();
      end
      rstn = 1'b1;
      repeat (IDLE_CYCLES) begin
         waitCycle();
         checkBit("Halt", 1'b1, Halt);
         checkBit("RRdy", 1'b0, RRdy);
      end
      runSegment();
      runSegment();   // resumes after the mid-program stop
      $display("bus requests %0d, checks %0d, errors %0d", reqCount, checkCount, errCount);
      if (errCount == 0) begin
         $display("Result: PASSED");
      end
      else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_TIME);
      errCount++;
      $display("timeout at %0t, the core did not halt", $time);
      $display("bus requests %0d, checks %0d, errors %0d", reqCount, checkCount, errCount);
      $display("Result: FAILED");
      $finish;
   end

endmodule

/* project.f */
+incdir+logic
logic/lanzonesPkg.sv
logic/instrDecoder.sv
logic/registerFile.sv
logic/busSequencer.sv
logic/lanzonesCore.sv
sim/lanzonesTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = lanzonesTb
FILELIST  = project.f
OBJDIR    = obj_dir
PASS_MSG  = Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
